//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      := tb_uart_top
FILELIST := files.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- files.f
rtl/uart_pkg.sv
rtl/axil_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
test/tb_uart_top.sv

//--- rtl/axil_pkg.sv
// AXI4-Lite package.
// Request and response bundles for a single 32-bit AXI4-Lite slave
// port, plus the response codes that the slave returns.

package axil_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////
  localparam int ADDR_W = 4;           // Byte address width.
  localparam int DATA_W = 32;          // Data bus width.
  localparam int STRB_W = DATA_W / 8;  // One strobe per byte lane.

  ////////////////////////////////////////////////////////////
  // Response codes
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    OKAY   = 2'b00,  // Normal access.
    SLVERR = 2'b10   // Slave refused the access.
  } resp_e;

  ////////////////////////////////////////////////////////////
  // Channel bundles
  ////////////////////////////////////////////////////////////
  // Master to slave.
  typedef struct packed {
    logic [ADDR_W-1:0] awaddr;   // Write address.
    logic              awvalid;  // Write address valid.
    logic [DATA_W-1:0] wdata;    // Write data.
    logic [STRB_W-1:0] wstrb;    // Write byte strobes.
    logic              wvalid;   // Write data valid.
    logic              bready;   // Master takes write response.
    logic [ADDR_W-1:0] araddr;   // Read address.
    logic              arvalid;  // Read address valid.
    logic              rready;   // Master takes read data.
  } axil_req_t;

  // Slave to master.
  typedef struct packed {
    logic              awready;  // Write address taken.
    logic              wready;   // Write data taken.
    resp_e             bresp;    // Write response code.
    logic              bvalid;   // Write response valid.
    logic              arready;  // Read address taken.
    logic [DATA_W-1:0] rdata;    // Read data.
    resp_e             rresp;    // Read response code.
    logic              rvalid;   // Read data valid.
  } axil_rsp_t;

endpackage

//--- rtl/uart_pkg.sv
// UART line package.
// Holds the 8N1 line format, the bit timing counters, the FSM state
// types and the register map of the memory-mapped UART.

package uart_pkg;

  ////////////////////////////////////////////////////////////
  // Line format and bit timing
  ////////////////////////////////////////////////////////////
  localparam int BAUD_DIV   = 32;            // Clock cycles per bit, 2604 for 19200 baud.
  localparam int HALF_DIV   = BAUD_DIV / 2;  // First sample point after the start edge.
  localparam int DATA_BITS  = 8;             // Payload bits per frame.
  localparam int FRAME_BITS = 10;            // Start, eight data and stop.

  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);       // Holds BAUD_DIV-1.
  localparam int BIT_CNT_W  = $clog2(FRAME_BITS + 1); // Holds FRAME_BITS.

  ////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////
  typedef enum logic {
    RX_IDLE,  // Waiting for a start edge.
    RX_RCV    // Sampling the frame.
  } rx_state_e;

  typedef enum logic {
    TX_IDLE,  // Line held high.
    TX_SEND   // Shifting out the frame.
  } tx_state_e;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    REG_DATA   = 4'h0,  // Tx byte on write, rx byte on read.
    REG_STATUS = 4'h4   // Ready, busy and overrun.
  } reg_addr_e;

  localparam int STAT_RDY_BIT  = 0;  // Received byte waiting.
  localparam int STAT_BUSY_BIT = 1;  // Transmitter busy.
  localparam int STAT_OVR_BIT  = 2;  // Sticky overrun.

endpackage

//--- rtl/uart_regs.sv
// UART register block.
// AXI4-Lite slave with a data register and a status register. Starts
// the transmitter, hands over received bytes and keeps a sticky
// overrun flag for bytes that arrive before the last one was read.

`timescale 1ns/1ns

module uart_regs (
  input  logic                clk,       // System clock.
  input  logic                rst_n,     // Async active low reset.
  input  axil_pkg::axil_req_t bus_req,   // Bus request from the master.
  output axil_pkg::axil_rsp_t bus_rsp,   // Bus response to the master.
  input  logic [7:0]          rx_data,   // Byte from the receiver.
  input  logic                rx_rdy,    // Receiver holds a byte.
  output logic                clr_rdy,   // Byte taken by software.
  output logic [7:0]          tx_data,   // Byte to the transmitter.
  output logic                tx_start,  // One-cycle send request.
  input  logic                tx_busy    // Transmitter busy.
);

  import axil_pkg::*;
  import uart_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal signals
  ////////////////////////////////////////////////////////////
  logic              awready_q;  // Shared by AW and W.
  logic              bvalid_q;
  resp_e             bresp_q;
  logic              arready_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  resp_e             rresp_q;
  logic              aw_hs;      // Write address and data taken.
  logic              ar_hs;      // Read address taken.
  logic              wr_go;      // Write starts the transmitter.
  logic              ovr_clr;    // Write clears overrun.
  resp_e             wr_resp;
  logic              rd_is_data; // Read of the data register.
  logic [DATA_W-1:0] rd_data;
  resp_e             rd_resp;
  logic [DATA_W-1:0] status;
  logic              rx_rdy_q;   // For the ready edge.
  logic              rdy_pend;   // Byte flagged but not yet read.
  logic              overrun;

  assign aw_hs = awready_q && bus_req.awvalid && bus_req.wvalid;
  assign ar_hs = arready_q && bus_req.arvalid;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    wr_go   = 1'b0;
    ovr_clr = 1'b0;
    wr_resp = OKAY;
    case (bus_req.awaddr)
      REG_DATA: begin
        if (tx_busy)
          wr_resp = SLVERR;  // Byte dropped.
        else
          wr_go = bus_req.wstrb[0];
      end
      REG_STATUS: ovr_clr = bus_req.wstrb[0] && bus_req.wdata[STAT_OVR_BIT];
      default:    wr_resp = SLVERR;
    endcase
  end

  always_comb begin
    status                = '0;
    status[STAT_RDY_BIT]  = rx_rdy;
    status[STAT_BUSY_BIT] = tx_busy;
    status[STAT_OVR_BIT]  = overrun;
  end

  always_comb begin
    rd_is_data = 1'b0;
    rd_data    = '0;  // Unmapped reads return zero.
    rd_resp    = OKAY;
    case (bus_req.araddr)
      REG_DATA: begin
        rd_is_data = 1'b1;
        rd_data    = {{(DATA_W - DATA_BITS){1'b0}}, rx_data};
      end
      REG_STATUS: rd_data = status;
      default:    rd_resp = SLVERR;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Channel handshakes
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      tx_start  <= 1'b0;
      clr_rdy   <= 1'b0;
    end else begin
      // Ready pulses for one cycle, no new accept while a response waits.
      awready_q <= !awready_q && !bvalid_q && bus_req.awvalid && bus_req.wvalid;
      arready_q <= !arready_q && !rvalid_q && bus_req.arvalid;
      if (aw_hs)
        bvalid_q <= 1'b1;
      else if (bus_req.bready)
        bvalid_q <= 1'b0;
      if (ar_hs)
        rvalid_q <= 1'b1;
      else if (bus_req.rready)
        rvalid_q <= 1'b0;
      tx_start <= aw_hs && wr_go;
      clr_rdy  <= ar_hs && rd_is_data && rx_rdy;  // Only when a byte was flagged.
    end
  end

  // Response payload, held while valid waits for ready.
  always_ff @(posedge clk) begin
    if (aw_hs)
      bresp_q <= wr_resp;
    if (aw_hs && wr_go)
      tx_data <= bus_req.wdata[7:0];
    if (ar_hs) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  ////////////////////////////////////////////////////////////
  // Overrun tracking
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_rdy_q <= 1'b0;
      rdy_pend <= 1'b0;
      overrun  <= 1'b0;
    end else begin
      rx_rdy_q <= rx_rdy;
      if (rx_rdy && !rx_rdy_q)
        rdy_pend <= 1'b1;  // New byte completed.
      else if (ar_hs && rd_is_data)
        rdy_pend <= 1'b0;
      if (rx_rdy && !rx_rdy_q && rdy_pend)
        overrun <= 1'b1;   // Previous byte never read.
      else if (aw_hs && ovr_clr)
        overrun <= 1'b0;
    end
  end

  assign bus_rsp.awready = awready_q;
  assign bus_rsp.wready  = awready_q;
  assign bus_rsp.bresp   = bresp_q;
  assign bus_rsp.bvalid  = bvalid_q;
  assign bus_rsp.arready = arready_q;
  assign bus_rsp.rdata   = rdata_q;
  assign bus_rsp.rresp   = rresp_q;
  assign bus_rsp.rvalid  = rvalid_q;

  // Responses hold until the master takes them.
  assert property (@(posedge clk) disable iff (!rst_n)
    bvalid_q && !bus_req.bready |=> bvalid_q && $stable(bresp_q));

  assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_q && !bus_req.rready |=> rvalid_q && $stable(rdata_q));

endmodule

//--- rtl/uart_rx.sv
// UART receiver.
// Double-flops the serial input, finds the start edge, samples each
// bit in the middle of its cell and flags a complete 8N1 byte.

`timescale 1ns/1ns

module uart_rx (
  input  logic       clk,      // System clock.
  input  logic       rst_n,    // Async active low reset.
  input  logic       rx,       // Serial input.
  input  logic       clr_rdy,  // Knocks down rx_rdy.
  output logic [7:0] rx_data,  // Last byte received.
  output logic       rx_rdy    // Byte waiting, cleared by clr_rdy or next start.
);

  import uart_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal signals
  ////////////////////////////////////////////////////////////
  logic                  rx_step;      // First synchronizer flop.
  logic                  rx_stable;    // Synchronized input.
  logic [DATA_BITS:0]    rx_shft_reg;  // Data bits plus stop bit.
  logic [BAUD_CNT_W-1:0] baud_cnt;     // Cycles left to the next sample.
  logic [BIT_CNT_W-1:0]  bit_cnt;      // Samples taken in this frame.
  logic                  start;        // Start edge seen in idle.
  logic                  shift;        // Sample point reached.
  logic                  receiving;    // Frame in progress.
  logic                  set_rdy;      // Frame complete.
  rx_state_e             state;
  rx_state_e             nxt_state;

  // Two-flop synchronizer, preset to the idle line level.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_step   <= 1'b1;
      rx_stable <= 1'b1;
    end else begin
      rx_step   <= rx;
      rx_stable <= rx_step;
    end
  end

  // Bits arrive LSB first, so shift in at the top.
  always_ff @(posedge clk) begin
    if (shift)
      rx_shft_reg <= {rx_stable, rx_shft_reg[DATA_BITS:1]};
  end

  // Counters reload to N-1 since the sample fires on zero.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (start) begin
      baud_cnt <= BAUD_CNT_W'(HALF_DIV - 1);  // Half a bit to mid start bit.
      bit_cnt  <= '0;
    end else if (shift) begin
      baud_cnt <= BAUD_CNT_W'(BAUD_DIV - 1);  // Full bit to the next middle.
      bit_cnt  <= bit_cnt + 1'b1;
    end else if (receiving) begin
      baud_cnt <= baud_cnt - 1'b1;
    end
  end

  assign shift   = receiving && (baud_cnt == '0);
  assign rx_data = rx_shft_reg[DATA_BITS-1:0];  // Stop bit dropped.

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= RX_IDLE;
    else
      state <= nxt_state;
  end

  // Ready flag, the next start wins over everything.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      rx_rdy <= 1'b0;
    else if (start || clr_rdy)
      rx_rdy <= 1'b0;
    else if (set_rdy)
      rx_rdy <= 1'b1;
  end

  always_comb begin
    nxt_state = state;
    start     = 1'b0;
    receiving = 1'b0;
    set_rdy   = 1'b0;
    case (state)
      RX_RCV: begin
        if (bit_cnt >= BIT_CNT_W'(FRAME_BITS)) begin
          set_rdy   = 1'b1;      // Stop bit sampled.
          nxt_state = RX_IDLE;
        end else begin
          receiving = 1'b1;
        end
      end
      default: begin
        if (!rx_stable) begin
          start     = 1'b1;      // Falling edge of the start bit.
          nxt_state = RX_RCV;
        end
      end
    endcase
  end

  // Counter stops at one full frame.
  assert property (@(posedge clk) disable iff (!rst_n)
    bit_cnt <= BIT_CNT_W'(FRAME_BITS));

  // Ready only rises once the FSM has left RCV.
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rx_rdy) |-> state == RX_IDLE);

endmodule

//--- rtl/uart_top.sv
// UART peripheral top level.
// AXI4-Lite register block in front of an 8N1 receiver and
// transmitter sharing one bit timing.

`timescale 1ns/1ns

module uart_top (
  input  logic                clk,      // System clock.
  input  logic                rst_n,    // Async active low reset.
  input  axil_pkg::axil_req_t bus_req,  // Bus request from the master.
  output axil_pkg::axil_rsp_t bus_rsp,  // Bus response to the master.
  input  logic                rx,       // Serial input.
  output logic                tx        // Serial output.
);

  ////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////
  logic [7:0] tx_data;   // Byte to send.
  logic       tx_start;  // Send pulse.
  logic       tx_busy;   // Frame on the line.
  logic [7:0] rx_data;   // Byte received.
  logic       rx_rdy;    // Byte waiting.
  logic       clr_rdy;   // Byte read by software.

  uart_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .rx_data  (rx_data),
    .rx_rdy   (rx_rdy),
    .clr_rdy  (clr_rdy),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .tx_busy  (tx_busy)
  );

  uart_rx u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .clr_rdy (clr_rdy),
    .rx_data (rx_data),
    .rx_rdy  (rx_rdy)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

endmodule

//--- rtl/uart_tx.sv
// UART transmitter.
// Frames one byte as 8N1 and shifts it out LSB first, one bit per
// baud period, with the line held high between frames.

`timescale 1ns/1ns

module uart_tx (
  input  logic       clk,       // System clock.
  input  logic       rst_n,     // Async active low reset.
  input  logic       tx_start,  // Load and send tx_data.
  input  logic [7:0] tx_data,   // Byte to send.
  output logic       tx,        // Serial output.
  output logic       tx_busy    // Frame on the line.
);

  import uart_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal signals
  ////////////////////////////////////////////////////////////
  logic [FRAME_BITS-1:0] tx_shft_reg;  // Stop, data, start.
  logic [BAUD_CNT_W-1:0] baud_cnt;     // Cycles left in the current bit.
  logic [BIT_CNT_W-1:0]  bit_cnt;      // Bits already sent.
  logic                  load;         // Accept a new byte.
  logic                  shift;        // Bit period over.
  logic                  sending;      // Frame in progress.
  logic                  done;         // Stop bit finished.
  tx_state_e             state;
  tx_state_e             nxt_state;

  // Shift register doubles as the line driver, so reset to idle high.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      tx_shft_reg <= '1;
    else if (load)
      tx_shft_reg <= {1'b1, tx_data, 1'b0};
    else if (shift)
      tx_shft_reg <= {1'b1, tx_shft_reg[FRAME_BITS-1:1]};  // Fill with idle level.
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (load) begin
      baud_cnt <= BAUD_CNT_W'(BAUD_DIV - 1);  // Start bit lasts BAUD_DIV cycles.
      bit_cnt  <= '0;
    end else if (shift) begin
      baud_cnt <= BAUD_CNT_W'(BAUD_DIV - 1);
      bit_cnt  <= bit_cnt + 1'b1;
    end else if (sending) begin
      baud_cnt <= baud_cnt - 1'b1;
    end
  end

  assign shift   = sending && (baud_cnt == '0);
  assign done    = shift && (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));
  assign tx      = tx_shft_reg[0];
  assign tx_busy = sending;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= TX_IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    load      = 1'b0;
    sending   = 1'b0;
    case (state)
      TX_SEND: begin
        sending = 1'b1;
        if (done)
          nxt_state = TX_IDLE;  // Last shift refills the line with ones.
      end
      default: begin
        if (tx_start) begin
          load      = 1'b1;
          nxt_state = TX_SEND;
        end
      end
    endcase
  end

  // Idle line stays at mark level.
  assert property (@(posedge clk) disable iff (!rst_n)
    state == TX_IDLE |-> tx);

  // Register block only starts an idle transmitter.
  assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy);

endmodule

//--- test/tb_uart_top.sv
// Testbench for the UART peripheral.
// Random AXI4-Lite traffic and serial frames go into the DUT. The serial
// output is monitored, and all responses are checked against a model of
// the register rules.

`timescale 1ns/1ns

module tb_uart_top;

  import uart_pkg::*;
  import axil_pkg::*;

  localparam int CLK_PERIOD  = 20;                            // 50 MHz.
  localparam int RST_CYCLES  = 16;
  localparam int N_TX        = 16;                            // Bytes written to REG_DATA.
  localparam int N_RX        = 16;                            // Bytes sent on rx.
  localparam int N_LOOP      = 8;                             // Bytes through the loopback.
  localparam int NUM_FRAMES  = N_TX + N_RX + 2 + 1 + N_LOOP;  // Overrun pair and busy test.
  localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_BITS * BAUD_DIV * CLK_PERIOD * 2;

  logic      clk;
  logic      rst_n;
  axil_req_t bus_req;
  axil_rsp_t bus_rsp;
  logic      rx_drv;    // Serial driver output.
  logic      loopback;  // Routes tx back into rx.
  logic      rx_line;
  logic      tx;

  logic [7:0] exp_tx_q[$];  // Bytes that must show up on tx.
  logic [8:0] mon_q[$];     // Stop bit and data seen on tx.
  logic [7:0] model_rx;     // Last byte the receiver should hold.
  logic       model_rdy;    // Byte received and not read yet.
  logic       model_ovr;    // Sticky overrun.
  int         errors = 0;
  int         checks = 0;

  assign rx_line = loopback ? tx : rx_drv;

  uart_top DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .rx      (rx_line),
    .tx      (tx)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Checking and model
  ////////////////////////////////////////////////////////////
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%08h, expected 0x%08h at %0t ns", name, got, exp, $time);
    end
  endtask

  // A finished frame while the last byte is unread sets overrun.
  task automatic model_byte_received(input logic [7:0] b);
    if (model_rdy)
      model_ovr = 1'b1;
    model_rdy = 1'b1;
    model_rx  = b;
  endtask

  // Status word while the transmitter is idle.
  function automatic logic [31:0] expected_status();
    logic [31:0] s;
    s                = '0;
    s[STAT_RDY_BIT]  = model_rdy;
    s[STAT_OVR_BIT]  = model_ovr;
    return s;
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus and serial drivers
  ////////////////////////////////////////////////////////////
  task automatic bus_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int unsigned delay;
    delay = $urandom % 4;  // Random bready stall.
    @(posedge clk);
    bus_req.awaddr  <= addr;
    bus_req.awvalid <= 1'b1;
    bus_req.wdata   <= data;
    bus_req.wstrb   <= 4'hf;
    bus_req.wvalid  <= 1'b1;
    @(posedge clk);
    while (!bus_rsp.awready) @(posedge clk);
    check("wready", 32'(bus_rsp.wready), 32'h1);  // Taken together with the address.
    bus_req.awvalid <= 1'b0;  // Handshake done on this edge.
    bus_req.wvalid  <= 1'b0;
    @(posedge clk);
    while (!bus_rsp.bvalid) @(posedge clk);
    resp = bus_rsp.bresp;
    repeat (delay) @(posedge clk);
    bus_req.bready <= 1'b1;
    @(posedge clk);
    bus_req.bready <= 1'b0;
  endtask

  task automatic bus_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int unsigned delay;
    delay = $urandom % 4;  // Random rready stall.
    @(posedge clk);
    bus_req.araddr  <= addr;
    bus_req.arvalid <= 1'b1;
    @(posedge clk);
    while (!bus_rsp.arready) @(posedge clk);
    bus_req.arvalid <= 1'b0;
    @(posedge clk);
    while (!bus_rsp.rvalid) @(posedge clk);
    data = bus_rsp.rdata;
    resp = bus_rsp.rresp;
    repeat (delay) @(posedge clk);
    bus_req.rready <= 1'b1;
    @(posedge clk);
    bus_req.rready <= 1'b0;
  endtask

  task automatic wait_tx_idle();
    logic [31:0] data;
    logic [1:0]  resp;
    bus_read(REG_STATUS, data, resp);
    while (data[STAT_BUSY_BIT]) bus_read(REG_STATUS, data, resp);
  endtask

  task automatic wait_rx_ready();
    logic [31:0] data;
    logic [1:0]  resp;
    bus_read(REG_STATUS, data, resp);
    while (!data[STAT_RDY_BIT]) bus_read(REG_STATUS, data, resp);
  endtask

  // One 8N1 frame on rx, each bit held for BAUD_DIV cycles.
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < FRAME_BITS; i++) begin
      @(posedge clk);
      rx_drv <= frame[i];
      repeat (BAUD_DIV - 1) @(posedge clk);
    end
  endtask

  task automatic compare_tx_bytes();
    logic [8:0] frame;
    wait_tx_idle();  // Monitor pushes at mid stop bit, before busy falls.
    check("tx frame count", mon_q.size(), exp_tx_q.size());
    while (mon_q.size() > 0 && exp_tx_q.size() > 0) begin
      frame = mon_q.pop_front();
      check("tx data", 32'(frame[7:0]), 32'(exp_tx_q.pop_front()));
      check("tx stop bit", 32'(frame[8]), 32'h1);
    end
    mon_q.delete();
    exp_tx_q.delete();
  endtask

  // Serial monitor, samples tx in the middle of each bit.
  initial begin : tx_monitor
    logic [8:0] frame;
    int         i;
    forever begin
      @(posedge clk);
      if (rst_n && !tx) begin
        repeat (HALF_DIV) @(posedge clk);
        check("tx start bit", 32'(tx), 32'h0);
        for (i = 0; i < 9; i++) begin
          repeat (BAUD_DIV) @(posedge clk);
          frame[i] = tx;
        end
        mon_q.push_back(frame);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rdata;
    logic [1:0]  resp;
    logic [7:0]  b;
    logic [7:0]  b2;
    int          n;
    void'($urandom(32'h1f6d));
    rst_n     = 1'b0;
    bus_req   = '0;
    rx_drv    = 1'b1;  // Idle line.
    loopback  = 1'b0;
    model_rx  = '0;
    model_rdy = 1'b0;
    model_ovr = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // Reset state.
    @(posedge clk);
    check("tx", 32'(tx), 32'h1);
    bus_read(REG_STATUS, rdata, resp);
    check("status", rdata, 32'h0);
    check("rresp", 32'(resp), 32'(OKAY));

    // Transmit path.
    for (n = 0; n < N_TX; n++) begin
      b = 8'($urandom);
      wait_tx_idle();
      bus_write(REG_DATA, {24'h0, b}, resp);
      check("bresp", 32'(resp), 32'(OKAY));
      exp_tx_q.push_back(b);
    end
    compare_tx_bytes();

    // Receive path, each byte read before the next.
    for (n = 0; n < N_RX; n++) begin
      b = 8'($urandom);
      send_byte(b);
      model_byte_received(b);
      wait_rx_ready();
      bus_read(REG_DATA, rdata, resp);
      check("rdata", rdata, {24'h0, model_rx});
      check("rresp", 32'(resp), 32'(OKAY));
      model_rdy = 1'b0;
      bus_read(REG_STATUS, rdata, resp);
      check("status", rdata, expected_status());
    end

    // Overrun from two unread bytes, then cleared by software.
    b  = 8'($urandom);
    b2 = 8'($urandom);
    send_byte(b);
    model_byte_received(b);
    send_byte(b2);
    model_byte_received(b2);
    wait_rx_ready();
    bus_read(REG_STATUS, rdata, resp);
    check("status", rdata, expected_status());
    bus_read(REG_DATA, rdata, resp);
    check("rdata", rdata, {24'h0, model_rx});
    model_rdy = 1'b0;
    bus_write(REG_STATUS, 32'(1) << STAT_OVR_BIT, resp);
    check("bresp", 32'(resp), 32'(OKAY));
    model_ovr = 1'b0;
    bus_read(REG_STATUS, rdata, resp);
    check("status", rdata, expected_status());

    // Busy write is dropped, unmapped address refused.
    b  = 8'($urandom);
    b2 = 8'($urandom);
    bus_write(REG_DATA, {24'h0, b}, resp);
    check("bresp", 32'(resp), 32'(OKAY));
    exp_tx_q.push_back(b);
    bus_write(REG_DATA, {24'h0, b2}, resp);
    check("bresp", 32'(resp), 32'(SLVERR));
    bus_read(4'h8, rdata, resp);
    check("rresp", 32'(resp), 32'(SLVERR));
    check("rdata", rdata, 32'h0);
    bus_write(4'h8, {24'h0, b2}, resp);
    check("bresp", 32'(resp), 32'(SLVERR));
    compare_tx_bytes();

    // Loopback with random response stalls.
    @(posedge clk);
    loopback <= 1'b1;
    for (n = 0; n < N_LOOP; n++) begin
      b = 8'($urandom);
      wait_tx_idle();
      bus_write(REG_DATA, {24'h0, b}, resp);
      check("bresp", 32'(resp), 32'(OKAY));
      exp_tx_q.push_back(b);
      wait_rx_ready();
      model_byte_received(b);
      bus_read(REG_DATA, rdata, resp);
      check("rdata", rdata, {24'h0, model_rx});
      model_rdy = 1'b0;
      bus_read(REG_STATUS, rdata, resp);  // Busy may still be high here.
      check("status rdy", 32'(rdata[STAT_RDY_BIT]), 32'(model_rdy));
      check("status overrun", 32'(rdata[STAT_OVR_BIT]), 32'(model_ovr));
    end
    compare_tx_bytes();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
